// ==== source/panelPkg.sv ====
/*
 * Shared definitions for the front-panel emulator.
 * Register geometry, scan geometry, command and scan-phase encodings.
 * Modules import this package in their headers.
 */
package panelPkg;

	// One displayed digit group is an octal digit
	localparam int DIGIT_BITS = 3;

	// Digit groups per visible register
	localparam int IP_DIGITS = 6;
	localparam int LOOP_DIGITS = 3;
	localparam int AP_DIGITS = 5;
	localparam int DATA_DIGITS = 3;

	localparam int IP_WIDTH = IP_DIGITS * DIGIT_BITS;
	localparam int LOOP_WIDTH = LOOP_DIGITS * DIGIT_BITS;
	localparam int AP_WIDTH = AP_DIGITS * DIGIT_BITS;
	localparam int DATA_WIDTH = DATA_DIGITS * DIGIT_BITS;

	// Column slots per full scan, numbered 0 to SCAN_COLUMNS-1
	localparam int SCAN_COLUMNS = 9;
	localparam int COL_BITS = 4;

	// Key matrix rows sampled on the scanned column
	localparam int ROW_COUNT = 7;

	// Register operations issued by the keyboard
	typedef enum logic [3:0] {
		cmdNone,
		cmdStep,
		cmdLoopInc,
		cmdLoopDec,
		cmdApInc,
		cmdApDec,
		cmdDataInc,
		cmdDataDec,
		cmdClear
	} panelCmd;

	// Sequencer step inside one column slot
	typedef enum logic [2:0] {
		phIdle,
		phClear,
		phCathode,
		phAnode,
		phKeyRead
	} scanPhase;

endpackage

// ==== source/keyDecoder.sv ====
/*
 * Key matrix decoder for the front panel.
 * Samples the row inputs on every key strobe of the scanned column and
 * issues one single-cycle command pulse for each new key press.
 */
module keyDecoder
	import panelPkg::*;
(
	input  logic                 clock,
	input  logic                 rstN,
	input  logic [ROW_COUNT-1:0] keyRows,
	input  logic [COL_BITS-1:0]  scanColumn,
	input  logic                 keyStrobe,
	output panelCmd              cmd,
	output logic                 cmdValid
);

	localparam int ROW_IDX_BITS = $clog2(ROW_COUNT);

	// Row code seen on the previous visit of each column
	logic [ROW_COUNT-1:0] prevRows [SCAN_COLUMNS];

	logic freshPress;
	logic [ROW_IDX_BITS-1:0] lowRow;
	panelCmd keyCmd;

	// Lowest set row wins
	always_comb begin
		lowRow = '0;
		for (int r = ROW_COUNT - 1; r >= 0; r--) begin
			if (keyRows[r]) begin
				lowRow = ROW_IDX_BITS'(r);
			end
		end
	end

	// A press is new when the column had all rows open on its last visit
	assign freshPress = keyStrobe && (keyRows != '0) && (prevRows[scanColumn] == '0);

	// Register keys sit in column 0 and the clear key in column 1
	always_comb begin
		keyCmd = cmdNone;
		if (scanColumn == COL_BITS'(0)) begin
			case (lowRow)
				ROW_IDX_BITS'(0): keyCmd = cmdStep;
				ROW_IDX_BITS'(1): keyCmd = cmdLoopInc;
				ROW_IDX_BITS'(2): keyCmd = cmdLoopDec;
				ROW_IDX_BITS'(3): keyCmd = cmdApInc;
				ROW_IDX_BITS'(4): keyCmd = cmdApDec;
				ROW_IDX_BITS'(5): keyCmd = cmdDataInc;
				ROW_IDX_BITS'(6): keyCmd = cmdDataDec;
				default:          keyCmd = cmdNone;
			endcase
		end else if (scanColumn == COL_BITS'(1) && lowRow == '0) begin
			keyCmd = cmdClear;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int c = 0; c < SCAN_COLUMNS; c++) begin
				prevRows[c] <= '0;
			end
			cmd <= cmdNone;
			cmdValid <= 1'b0;
		end else begin
			cmdValid <= freshPress && (keyCmd != cmdNone);
			if (keyStrobe) begin
				prevRows[scanColumn] <= keyRows;
				cmd <= keyCmd;
			end
		end
	end

endmodule

// ==== source/counterBank.sv ====
/*
 * Visible machine state of the panel: instruction pointer, loop depth,
 * address pointer and data cell. Applies command pulses from the key
 * decoder on the edge where cmdValid is high; counts wrap at full width.
 */
module counterBank
	import panelPkg::*;
(
	input  logic                  clock,
	input  logic                  rstN,
	input  panelCmd               cmd,
	input  logic                  cmdValid,
	output logic [IP_WIDTH-1:0]   ipCount,
	output logic [LOOP_WIDTH-1:0] loopCount,
	output logic [AP_WIDTH-1:0]   apCount,
	output logic [DATA_WIDTH-1:0] dataCount
);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			ipCount <= '0;
			loopCount <= '0;
			apCount <= '0;
			dataCount <= '0;
		end else if (cmdValid) begin
			case (cmd)
				// Single step advances the instruction pointer
				cmdStep: begin
					ipCount <= ipCount + 1'b1;
				end
				cmdLoopInc: begin
					loopCount <= loopCount + 1'b1;
				end
				cmdLoopDec: begin
					loopCount <= loopCount - 1'b1;
				end
				cmdApInc: begin
					apCount <= apCount + 1'b1;
				end
				cmdApDec: begin
					apCount <= apCount - 1'b1;
				end
				cmdDataInc: begin
					dataCount <= dataCount + 1'b1;
				end
				cmdDataDec: begin
					dataCount <= dataCount - 1'b1;
				end
				// Panel reset of the whole machine state
				cmdClear: begin
					ipCount <= '0;
					loopCount <= '0;
					apCount <= '0;
					dataCount <= '0;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== source/displayScanner.sv ====
/*
 * Nixie panel scanner. Every TICK_DIV clocks it moves to the next column
 * and runs clear, cathode, anode and key-read strobes on the shared
 * panel bus, one cycle each. panelData is registered with the strobes.
 */
module displayScanner
	import panelPkg::*;
#(
	parameter int TICK_DIV = 16
) (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic [IP_WIDTH-1:0]   ipCount,
	input  logic [LOOP_WIDTH-1:0] loopCount,
	input  logic [AP_WIDTH-1:0]   apCount,
	input  logic [DATA_WIDTH-1:0] dataCount,
	output logic [COL_BITS-1:0]   scanColumn,
	output logic                  keyStrobe,
	output logic [7:0]            panelData,
	output logic                  tubeClear,
	output logic                  tubeCathode,
	output logic                  tubeAnode,
	output logic                  keyRead
);

	localparam int TICK_BITS = $clog2(TICK_DIV);
	// First column of the instruction pointer on the lower tubes
	localparam int IP_FIRST_COL = LOOP_DIGITS;
	// Address pointer starts after the blank upper tube of column 3
	localparam int AP_FIRST_COL = DATA_DIGITS + 1;

	logic [TICK_BITS-1:0] tickCount;
	logic tick;
	logic scanRun;
	scanPhase phase;
	scanPhase nextPhase;
	logic [DIGIT_BITS-1:0] lowerDigit;
	logic [DIGIT_BITS-1:0] upperDigit;

	assign tick = (tickCount == TICK_BITS'(TICK_DIV - 1));

	always_ff @(posedge clock) begin
		if (!rstN) begin
			tickCount <= '0;
		end else if (tick) begin
			tickCount <= '0;
		end else begin
			tickCount <= tickCount + 1'b1;
		end
	end

	// First tick after reset shows column 0 itself
	always_ff @(posedge clock) begin
		if (!rstN) begin
			scanColumn <= '0;
			scanRun <= 1'b0;
		end else if (tick) begin
			scanRun <= 1'b1;
			if (scanRun) begin
				if (scanColumn == COL_BITS'(SCAN_COLUMNS - 1)) begin
					scanColumn <= '0;
				end else begin
					scanColumn <= scanColumn + 1'b1;
				end
			end
		end
	end

	always_comb begin
		case (phase)
			phIdle:    nextPhase = tick ? phClear : phIdle;
			phClear:   nextPhase = phCathode;
			phCathode: nextPhase = phAnode;
			phAnode:   nextPhase = phKeyRead;
			default:   nextPhase = phIdle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			phase <= phIdle;
			tubeClear <= 1'b0;
			tubeCathode <= 1'b0;
			tubeAnode <= 1'b0;
			keyRead <= 1'b0;
		end else begin
			phase <= nextPhase;
			tubeClear <= (nextPhase == phClear);
			tubeCathode <= (nextPhase == phCathode);
			tubeAnode <= (nextPhase == phAnode);
			keyRead <= (nextPhase == phKeyRead);
		end
	end

	assign keyStrobe = keyRead;

	// Loop and ip digits on the lower tube, data and ap digits on the upper tube
	always_comb begin
		lowerDigit = '0;
		upperDigit = '0;
		if (scanColumn < IP_FIRST_COL) begin
			lowerDigit = loopCount[scanColumn * DIGIT_BITS +: DIGIT_BITS];
		end else begin
			lowerDigit = ipCount[(scanColumn - IP_FIRST_COL) * DIGIT_BITS +: DIGIT_BITS];
		end
		if (scanColumn < DATA_DIGITS) begin
			upperDigit = dataCount[scanColumn * DIGIT_BITS +: DIGIT_BITS];
		end else if (scanColumn >= AP_FIRST_COL) begin
			upperDigit = apCount[(scanColumn - AP_FIRST_COL) * DIGIT_BITS +: DIGIT_BITS];
		end
	end

	// Bus byte follows the phase entered on this edge
	always_ff @(posedge clock) begin
		case (nextPhase)
			phCathode: panelData <= {1'b0, upperDigit, 1'b0, lowerDigit};
			phAnode:   panelData <= {{(8 - COL_BITS){1'b0}}, scanColumn};
			default:   panelData <= '0;
		endcase
	end

endmodule

// ==== source/panelEmulator.sv ====
/*
 * Top level of the front-panel emulator. Connects the key decoder,
 * the register bank and the panel scanner; TICK_DIV sets the column rate.
 */
module panelEmulator
	import panelPkg::*;
#(
	parameter int TICK_DIV = 16
) (
	input  logic                 clock,
	input  logic                 rstN,
	input  logic [ROW_COUNT-1:0] keyRows,
	output logic [7:0]           panelData,
	output logic                 tubeClear,
	output logic                 tubeCathode,
	output logic                 tubeAnode,
	output logic                 keyRead
);

	logic [COL_BITS-1:0] scanColumn;
	logic keyStrobe;
	panelCmd cmd;
	logic cmdValid;

	logic [IP_WIDTH-1:0] ipCount;
	logic [LOOP_WIDTH-1:0] loopCount;
	logic [AP_WIDTH-1:0] apCount;
	logic [DATA_WIDTH-1:0] dataCount;

	keyDecoder keyDecoder (
		.clock(clock),
		.rstN(rstN),
		.keyRows(keyRows),
		.scanColumn(scanColumn),
		.keyStrobe(keyStrobe),
		.cmd(cmd),
		.cmdValid(cmdValid)
	);

	counterBank counterBank (
		.clock(clock),
		.rstN(rstN),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.ipCount(ipCount),
		.loopCount(loopCount),
		.apCount(apCount),
		.dataCount(dataCount)
	);

	// Scanner also supplies the column the keyboard is read on
	displayScanner #(
		.TICK_DIV(TICK_DIV)
	) displayScanner (
		.clock(clock),
		.rstN(rstN),
		.ipCount(ipCount),
		.loopCount(loopCount),
		.apCount(apCount),
		.dataCount(dataCount),
		.scanColumn(scanColumn),
		.keyStrobe(keyStrobe),
		.panelData(panelData),
		.tubeClear(tubeClear),
		.tubeCathode(tubeCathode),
		.tubeAnode(tubeAnode),
		.keyRead(keyRead)
	);

endmodule

// ==== tests/panelChecker.sv ====
/*
 * Panel bus checker. Keeps a model of the four registers, follows the
 * strobe sequence and compares every bus byte with the digit map.
 * Prints one line per finished test and the counts at the end.
 */
module panelChecker
	import panelPkg::*;
#(
	parameter int TICK_DIV = 8
) (
	input  logic                 clock,
	input  logic                 rstN,
	input  logic [7:0]           panelData,
	input  logic                 tubeClear,
	input  logic                 tubeCathode,
	input  logic                 tubeAnode,
	input  logic                 keyRead,
	input  logic                 pressReq,
	input  logic [COL_BITS-1:0]  pressCol,
	input  logic [ROW_COUNT-1:0] pressRows,
	input  logic                 testDone,
	input  int                   testId,
	input  logic                 runDone,
	output int                   errorCount
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [IP_WIDTH-1:0] ipModel;
	logic [LOOP_WIDTH-1:0] loopModel;
	logic [AP_WIDTH-1:0] apModel;
	logic [DATA_WIDTH-1:0] dataModel;

	logic [3:0] prevStrobes;
	int slotCol;
	logic firstSlot;
	int sinceReset;
	logic pending;
	int heldCol;
	panelCmd heldCmd;
	int testErrors = 0;
	int testCount = 0;
	int failedTests = 0;
	int checkCount = 0;

	initial errorCount = 0;

	function automatic int lowestRow(input logic [ROW_COUNT-1:0] rows);
		int low;
		low = 0;
		for (int r = ROW_COUNT - 1; r >= 0; r--) begin
			if (rows[r]) begin
				low = r;
			end
		end
		return low;
	endfunction

	// Register keys sit in column 0 and the clear key in column 1 row 0
	function automatic panelCmd commandFor(input int col, input int row);
		if (col == 0) begin
			case (row)
				0: return cmdStep;
				1: return cmdLoopInc;
				2: return cmdLoopDec;
				3: return cmdApInc;
				4: return cmdApDec;
				5: return cmdDataInc;
				6: return cmdDataDec;
				default: return cmdNone;
			endcase
		end
		if (col == 1 && row == 0) begin
			return cmdClear;
		end
		return cmdNone;
	endfunction

	task automatic applyCommand(input panelCmd c);
		case (c)
			cmdStep: ipModel = ipModel + 1'b1;
			cmdLoopInc: loopModel = loopModel + 1'b1;
			cmdLoopDec: loopModel = loopModel - 1'b1;
			cmdApInc: apModel = apModel + 1'b1;
			cmdApDec: apModel = apModel - 1'b1;
			cmdDataInc: dataModel = dataModel + 1'b1;
			cmdDataDec: dataModel = dataModel - 1'b1;
			cmdClear: begin
				ipModel = '0;
				loopModel = '0;
				apModel = '0;
				dataModel = '0;
			end
			default: begin
			end
		endcase
	endtask

	// Lower digit from loop or ip, upper digit from data, a blank or ap
	function automatic logic [7:0] cathodeByte(input int col);
		logic [DIGIT_BITS-1:0] lower;
		logic [DIGIT_BITS-1:0] upper;
		if (col < LOOP_DIGITS) begin
			lower = loopModel[col * DIGIT_BITS +: DIGIT_BITS];
		end else begin
			lower = ipModel[(col - LOOP_DIGITS) * DIGIT_BITS +: DIGIT_BITS];
		end
		if (col < DATA_DIGITS) begin
			upper = dataModel[col * DIGIT_BITS +: DIGIT_BITS];
		end else if (col == DATA_DIGITS) begin
			upper = '0;
		end else begin
			upper = apModel[(col - DATA_DIGITS - 1) * DIGIT_BITS +: DIGIT_BITS];
		end
		return {1'b0, upper, 1'b0, lower};
	endfunction

	task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("%0t %s", $time, what);
		errorCount++;
		testErrors++;
	endtask

	always @(posedge clock) begin
		logic [3:0] strobes;
		logic orderOk;
		string verdict;
		strobes = {tubeClear, tubeCathode, tubeAnode, keyRead};
		if (!rstN) begin
			ipModel = '0;
			loopModel = '0;
			apModel = '0;
			dataModel = '0;
			prevStrobes = '0;
			slotCol = 0;
			firstSlot = 1'b1;
			sinceReset = 0;
			pending = 1'b0;
		end else begin
			sinceReset++;
			case (prevStrobes)
				4'b1000: orderOk = (strobes == 4'b0100);
				4'b0100: orderOk = (strobes == 4'b0010);
				4'b0010: orderOk = (strobes == 4'b0001);
				default: orderOk = (strobes == 4'b0000) || (strobes == 4'b1000);
			endcase
			if (!orderOk) begin
				reportFailure($sformatf("strobes out of order, saw %b after %b", strobes, prevStrobes));
			end
			if (tubeClear) begin
				if (firstSlot) begin
					if (sinceReset < TICK_DIV || sinceReset > TICK_DIV + 2) begin
						reportFailure($sformatf("first clear strobe came %0d cycles after reset",
							sinceReset));
					end
					slotCol = 0;
					firstSlot = 1'b0;
				end else begin
					slotCol = (slotCol == SCAN_COLUMNS - 1) ? 0 : slotCol + 1;
				end
				checkValue("panelData on tubeClear", panelData, 8'h00);
			end
			if (tubeCathode) begin
				checkValue("panelData on tubeCathode", panelData, cathodeByte(slotCol));
			end
			if (tubeAnode) begin
				checkValue("panelData on tubeAnode", panelData, 8'(slotCol));
			end
			if (keyRead) begin
				checkValue("panelData on keyRead", panelData, 8'h00);
				// Press takes effect on the first key read of its column
				if (pending && slotCol == heldCol) begin
					applyCommand(heldCmd);
					pending = 1'b0;
				end
			end
			if (pressReq) begin
				pending = 1'b1;
				heldCol = pressCol;
				heldCmd = commandFor(pressCol, lowestRow(pressRows));
			end
			if (testDone) begin
				if (pending) begin
					reportFailure($sformatf("press on column %0d never reached a key read", heldCol));
					pending = 1'b0;
				end
				verdict = (testErrors == 0) ? "ok" : $sformatf("%0d errors", testErrors);
				if (testId == 0) begin
					$display("test 0 reset and first scan: %s", verdict);
				end else begin
					$display("test %0d press column %0d %s: %s", testId, heldCol, heldCmd.name(),
						verdict);
				end
				testCount++;
				if (testErrors != 0) begin
					failedTests++;
				end
				testErrors = 0;
			end
			if (runDone) begin
				$display("tests %0d, failed %0d, checks %0d, errors %0d", testCount, failedTests,
					checkCount, errorCount);
			end
			prevStrobes = strobes;
		end
	end

endmodule

// ==== tests/tbPanelEmulator.sv ====
/*
 * Testbench for the front-panel emulator. Presses random keys from a fixed
 * seed on the scanned key matrix and holds each one over several scans.
 * panelChecker watches the panel bus; this module ends the run.
 */
module tbPanelEmulator
	import panelPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TICK = 8;
	localparam int PRESSES = 60;
	// Four scans per press, plus a fifth of that as margin
	localparam int TIMEOUT_CYCLES = PRESSES * 4 * SCAN_COLUMNS * TICK * 12 / 10;

	logic clock;
	logic rstN;
	logic [ROW_COUNT-1:0] keyRows;
	logic [7:0] panelData;
	logic tubeClear;
	logic tubeCathode;
	logic tubeAnode;
	logic keyRead;

	logic held;
	logic [COL_BITS-1:0] chosenCol;
	logic [ROW_COUNT-1:0] chosenRows;
	logic [COL_BITS-1:0] lastCol;
	logic pressReq;
	logic testDone;
	int testId;
	logic runDone;
	int errorCount;
	int cycleCount = 0;

	always #2 clock = ~clock;

	panelEmulator #(
		.TICK_DIV(TICK)
	) UUT (
		.clock(clock),
		.rstN(rstN),
		.keyRows(keyRows),
		.panelData(panelData),
		.tubeClear(tubeClear),
		.tubeCathode(tubeCathode),
		.tubeAnode(tubeAnode),
		.keyRead(keyRead)
	);

	panelChecker #(
		.TICK_DIV(TICK)
	) panelCheck (
		.clock(clock),
		.rstN(rstN),
		.panelData(panelData),
		.tubeClear(tubeClear),
		.tubeCathode(tubeCathode),
		.tubeAnode(tubeAnode),
		.keyRead(keyRead),
		.pressReq(pressReq),
		.pressCol(chosenCol),
		.pressRows(chosenRows),
		.testDone(testDone),
		.testId(testId),
		.runDone(runDone),
		.errorCount(errorCount)
	);

	// Key switch closes while its column is the one lit on the anodes
	always @(posedge clock) begin
		logic [COL_BITS-1:0] colNow;
		colNow = tubeAnode ? panelData[COL_BITS-1:0] : lastCol;
		if (tubeAnode) begin
			lastCol <= panelData[COL_BITS-1:0];
		end
		keyRows <= (held && colNow == chosenCol) ? chosenRows : '0;
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Returns on the edge after the anode strobe of the last column
	task automatic waitScans(input int count);
		int seen;
		seen = 0;
		while (seen < count) begin
			@(posedge clock);
			if (tubeAnode && panelData == 8'(SCAN_COLUMNS - 1)) begin
				seen++;
			end
		end
	endtask

	task automatic finishTest(input int id);
		testDone <= 1'b1;
		testId <= id;
		@(posedge clock);
		testDone <= 1'b0;
	endtask

	initial begin
		int col;
		int row;
		int extra;
		logic [ROW_COUNT-1:0] rows;
		void'($urandom(17));
		clock = 1'b0;
		rstN = 1'b0;
		keyRows = '0;
		held = 1'b0;
		chosenCol = '0;
		chosenRows = '0;
		lastCol = '0;
		pressReq = 1'b0;
		testDone = 1'b0;
		testId = 0;
		runDone = 1'b0;
		repeat (2) @(posedge clock);
		rstN <= 1'b1;

		waitScans(1);
		finishTest(0);

		for (int p = 0; p < PRESSES; p++) begin
			// First press decrements the loop depth from zero
			if (p == 0) begin
				col = 0;
				row = 2;
			end else if (p == PRESSES / 2 || $urandom % 16 == 0) begin
				col = 1;
				row = 0;
			end else begin
				col = 0;
				row = $urandom % ROW_COUNT;
			end
			rows = '0;
			rows[row] = 1'b1;
			// Sometimes a higher row closes along with it
			if (row < ROW_COUNT - 1 && $urandom % 4 == 0) begin
				extra = row + 1 + $urandom % (ROW_COUNT - 1 - row);
				rows[extra] = 1'b1;
			end
			chosenCol <= COL_BITS'(col);
			chosenRows <= rows;
			held <= 1'b1;
			pressReq <= 1'b1;
			@(posedge clock);
			pressReq <= 1'b0;
			waitScans(2);
			held <= 1'b0;
			waitScans(2);
			finishTest(p + 1);
		end

		runDone <= 1'b1;
		@(posedge clock);
		runDone <= 1'b0;
		@(negedge clock);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
source/panelPkg.sv
source/keyDecoder.sv
source/counterBank.sv
source/displayScanner.sv
source/panelEmulator.sv
tests/panelChecker.sv
tests/tbPanelEmulator.sv

// ==== Bender.yml ====
package:
  name: panel_emulator

sources:
  - files:
      - source/panelPkg.sv
      - source/keyDecoder.sv
      - source/counterBank.sv
      - source/displayScanner.sv
      - source/panelEmulator.sv
  - target: test
    files:
      - tests/panelChecker.sv
      - tests/tbPanelEmulator.sv
